/* llc_cfg.svh */
/*
  LLC hit/miss stage configuration
  geometry of the tag store and widths of the descriptor fields
*/
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

// associativity, number of ways per set
`define LLC_WAYS 4
// number of sets in the tag store
`define LLC_SETS 16
// set index bits, log2 of LLC_SETS
`define LLC_INDEX_W 4
// byte offset inside one cache line
`define LLC_OFFSET_W 6

// full descriptor address
`define LLC_ADDR_W 32
// tag is whatever is left above index and offset
`define LLC_TAG_W (`LLC_ADDR_W - `LLC_INDEX_W - `LLC_OFFSET_W)

// transaction id of a descriptor
`define LLC_ID_W 4
// in-flight miss counter, one per id
`define LLC_CNT_W 3

`endif

/* llc_pkg.sv */
/*
  LLC hit/miss package
  field types shared by the tag store, lock table, miss counters and controller
*/
`default_nettype none

`include "llc_cfg.svh"

package llc_pkg;

  //////////////////////////////////////////////////////////////////////
  // field types
  //////////////////////////////////////////////////////////////////////

  // one-hot way select, one bit per way
  typedef logic [`LLC_WAYS-1:0]    way_ind_t;
  typedef logic [`LLC_INDEX_W-1:0] index_t;
  typedef logic [`LLC_TAG_W-1:0]   tag_t;
  typedef logic [`LLC_ADDR_W-1:0]  addr_t;
  typedef logic [`LLC_ID_W-1:0]    id_t;
  // misses in flight for one id
  typedef logic [`LLC_CNT_W-1:0]   cnt_t;

  //////////////////////////////////////////////////////////////////////
  // state encodings
  //////////////////////////////////////////////////////////////////////

  // tag store: zeroing sweep, waiting for a lookup, holding a response
  typedef enum logic [1:0] {
    TS_INIT,
    TS_IDLE,
    TS_RESP
  } store_state_e;

  // controller: no descriptor, lookup response due, output pending
  typedef enum logic [1:0] {
    HM_IDLE,
    HM_LOOKUP,
    HM_SEND
  } hm_state_e;

endpackage

`default_nettype wire

/* llc_tag_store.sv */
/*
  LLC tag store
  tag, valid and dirty bits per line plus a replacement pointer per set,
  zeroed by a sweep after reset, then one lookup at a time with victim choice
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module llc_tag_store (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  input  wire llc_pkg::index_t   req_index_i,
  input  wire llc_pkg::tag_t     req_tag_i,
  input  wire logic              req_write_i,
  output logic                   res_valid_o,
  input  wire logic              res_ready_i,
  output logic                   res_hit_o,
  output llc_pkg::way_ind_t      res_way_o,
  output logic                   res_evict_o,
  output llc_pkg::tag_t          res_evict_tag_o
);

  // storage arrays, cleared by the init sweep
  llc_pkg::tag_t     tag_q   [`LLC_SETS][`LLC_WAYS];
  llc_pkg::way_ind_t valid_q [`LLC_SETS];
  llc_pkg::way_ind_t dirty_q [`LLC_SETS];
  // one-hot pointer, next way to replace
  llc_pkg::way_ind_t ptr_q   [`LLC_SETS];

  llc_pkg::store_state_e state_q, state_d;
  llc_pkg::index_t       init_idx_q;

  // lookup results of the addressed set
  llc_pkg::way_ind_t rd_valid, rd_dirty, rd_ptr;
  llc_pkg::way_ind_t hit_way, invalid, lowest_inv, victim, ptr_next;
  llc_pkg::tag_t     ptr_tag;
  logic              lk_hit, all_valid, lk_evict, lookup;

  // response registers
  logic              res_hit_q, res_evict_q;
  llc_pkg::way_ind_t res_way_q;
  llc_pkg::tag_t     res_evict_tag_q;

  //////////////////////////////////////////////////////////////////////
  // lookup and victim choice
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_valid = valid_q[req_index_i];
    rd_dirty = dirty_q[req_index_i];
    rd_ptr   = ptr_q[req_index_i];
    hit_way  = '0;
    ptr_tag  = '0;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      // tag match only counts on a valid way
      if (rd_valid[w] && (tag_q[req_index_i][w] == req_tag_i)) begin
        hit_way[w] = 1'b1;
      end
      // tag held by the way the pointer names
      if (rd_ptr[w]) begin
        ptr_tag = ptr_tag | tag_q[req_index_i][w];
      end
    end
    lk_hit     = |hit_way;
    invalid    = ~rd_valid;
    // isolate lowest set bit of the invalid mask
    lowest_inv = invalid & llc_pkg::way_ind_t'(~invalid + 1'b1);
    all_valid  = &rd_valid;
    victim     = all_valid ? rd_ptr : lowest_inv;
    // dirty line is only written back when a valid line is replaced
    lk_evict   = ~lk_hit & all_valid & |(rd_dirty & rd_ptr);
    ptr_next   = {rd_ptr[`LLC_WAYS-2:0], rd_ptr[`LLC_WAYS-1]};
  end

  assign lookup = (state_q == llc_pkg::TS_IDLE) & req_valid_i;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      llc_pkg::TS_INIT: begin
        // one set per cycle, done after the last set
        if (init_idx_q == llc_pkg::index_t'(`LLC_SETS - 1)) begin
          state_d = llc_pkg::TS_IDLE;
        end
      end
      llc_pkg::TS_IDLE: begin
        if (req_valid_i) begin
          state_d = llc_pkg::TS_RESP;
        end
      end
      llc_pkg::TS_RESP: begin
        if (res_ready_i) begin
          state_d = llc_pkg::TS_IDLE;
        end
      end
      default: state_d = llc_pkg::TS_INIT;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= llc_pkg::TS_INIT;
      init_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == llc_pkg::TS_INIT) begin
        init_idx_q <= init_idx_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array and response update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == llc_pkg::TS_INIT) begin
      valid_q[init_idx_q] <= '0;
      dirty_q[init_idx_q] <= '0;
      ptr_q[init_idx_q]   <= llc_pkg::way_ind_t'(1);
      for (int w = 0; w < `LLC_WAYS; w++) begin
        tag_q[init_idx_q][w] <= '0;
      end
    end else if (lookup) begin
      if (lk_hit) begin
        // a write hit marks the line dirty
        dirty_q[req_index_i] <= rd_dirty | (req_write_i ? hit_way : '0);
      end else begin
        valid_q[req_index_i] <= rd_valid | victim;
        dirty_q[req_index_i] <= req_write_i ? (rd_dirty | victim) : (rd_dirty & ~victim);
        for (int w = 0; w < `LLC_WAYS; w++) begin
          if (victim[w]) begin
            tag_q[req_index_i][w] <= req_tag_i;
          end
        end
        // pointer only moves on a real replacement
        if (all_valid) begin
          ptr_q[req_index_i] <= ptr_next;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup) begin
      res_hit_q       <= lk_hit;
      res_way_q       <= lk_hit ? hit_way : victim;
      res_evict_q     <= lk_evict;
      res_evict_tag_q <= ptr_tag;
    end
  end

  assign req_ready_o     = (state_q == llc_pkg::TS_IDLE);
  assign res_valid_o     = (state_q == llc_pkg::TS_RESP);
  assign res_hit_o       = res_hit_q;
  assign res_way_o       = res_way_q;
  assign res_evict_o     = res_evict_q;
  assign res_evict_tag_o = res_evict_tag_q;

endmodule

`default_nettype wire

/* llc_miss_counters.sv */
/*
  LLC miss counters
  one counter per transaction id tracking misses still downstream
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module llc_miss_counters (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,
  // id of the descriptor held by the controller
  input  wire llc_pkg::id_t  id_i,
  input  wire logic          up_i,
  // miss-done strobe from downstream
  input  wire logic          down_i,
  input  wire llc_pkg::id_t  down_id_i,
  output logic               to_miss_o,
  output logic               stall_o
);

  localparam int unsigned NumIds = 1 << `LLC_ID_W;

  llc_pkg::cnt_t     cnt_q [NumIds];
  logic [NumIds-1:0] inc, dec;

  // decode the strobes per id
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      inc[i] = up_i & (id_i == llc_pkg::id_t'(i));
      dec[i] = down_i & (down_id_i == llc_pkg::id_t'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NumIds; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        // up and down on the same id cancel
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // misses in flight force hits onto the miss path
  assign to_miss_o = |cnt_q[id_i];
  // full counter, no further miss may be counted
  assign stall_o   = &cnt_q[id_i];

endmodule

`default_nettype wire

/* llc_lock_table.sv */
/*
  LLC lock table
  one lock bit per line, set when a descriptor leaves for a line,
  cleared by the unlock strobe from downstream
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module llc_lock_table (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  // queried line, also the line to lock
  input  wire logic              lock_i,
  input  wire llc_pkg::index_t   index_i,
  input  wire llc_pkg::way_ind_t way_i,
  // release of a line by downstream
  input  wire logic              unlock_i,
  input  wire llc_pkg::index_t   unlock_index_i,
  input  wire llc_pkg::way_ind_t unlock_way_i,
  output logic                   locked_o
);

  localparam int unsigned NumSets = `LLC_SETS;

  llc_pkg::way_ind_t lock_q [NumSets];

  //////////////////////////////////////////////////////////////////////
  // lock bits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < NumSets; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < NumSets; s++) begin
        // clear first, a lock on the same line wins
        if (lock_i && (index_i == llc_pkg::index_t'(s))) begin
          lock_q[s] <= (unlock_i && (unlock_index_i == llc_pkg::index_t'(s))) ?
                       ((lock_q[s] & ~unlock_way_i) | way_i) : (lock_q[s] | way_i);
        end else if (unlock_i && (unlock_index_i == llc_pkg::index_t'(s))) begin
          lock_q[s] <= lock_q[s] & ~unlock_way_i;
        end
      end
    end
  end

  // queried line in use downstream
  assign locked_o = |(lock_q[index_i] & way_i);

endmodule

`default_nettype wire

/* llc_hit_miss.sv */
/*
  LLC hit/miss stage
  looks up one descriptor at a time in the tag store and routes it to the
  hit or miss path, held back while its line is locked or its id stalls
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module llc_hit_miss (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  // input descriptor
  input  wire logic              valid_i,
  output logic                   ready_o,
  input  wire llc_pkg::addr_t    addr_i,
  input  wire logic              rw_i,
  input  wire llc_pkg::id_t      id_i,
  // output handshakes, shared fields
  output logic                   hit_valid_o,
  input  wire logic              hit_ready_i,
  output logic                   miss_valid_o,
  input  wire logic              miss_ready_i,
  output llc_pkg::addr_t         addr_o,
  output logic                   rw_o,
  output llc_pkg::id_t           id_o,
  output llc_pkg::way_ind_t      way_o,
  output logic                   refill_o,
  output logic                   evict_o,
  output llc_pkg::tag_t          evict_tag_o,
  // returns from downstream
  input  wire logic              unlock_i,
  input  wire llc_pkg::index_t   unlock_index_i,
  input  wire llc_pkg::way_ind_t unlock_way_i,
  input  wire logic              cnt_down_i,
  input  wire llc_pkg::id_t      cnt_down_id_i
);

  llc_pkg::hm_state_e state_q, state_d;

  // held descriptor and its registered lookup response
  llc_pkg::addr_t    addr_q;
  logic              rw_q;
  llc_pkg::id_t      id_q;
  logic              hit_q, evict_q;
  llc_pkg::way_ind_t way_q;
  llc_pkg::tag_t     evict_tag_q;
  // an output valid is up and its routing is frozen
  logic              raised_q, route_miss_q;

  logic              store_req_valid, store_req_ready, store_res_valid, store_res_ready;
  logic              res_hit, res_evict;
  llc_pkg::way_ind_t res_way;
  llc_pkg::tag_t     res_evict_tag;
  logic              to_miss, cnt_stall, cnt_up, lock_req, locked;

  logic              accept, in_lookup, have_res, route_miss, send, xfer;
  logic              cur_hit, cur_evict;
  llc_pkg::way_ind_t cur_way;
  llc_pkg::tag_t     cur_evict_tag;

  //////////////////////////////////////////////////////////////////////
  // handshakes and routing
  //////////////////////////////////////////////////////////////////////

  assign ready_o         = (state_q == llc_pkg::HM_IDLE) & store_req_ready;
  assign accept          = valid_i & ready_o;
  assign store_req_valid = (state_q == llc_pkg::HM_IDLE) & valid_i;
  assign in_lookup       = (state_q == llc_pkg::HM_LOOKUP);
  assign store_res_ready = in_lookup;
  assign have_res        = (in_lookup & store_res_valid) | (state_q == llc_pkg::HM_SEND);

  // response goes straight out in the lookup cycle, from registers after
  assign cur_hit       = in_lookup ? res_hit       : hit_q;
  assign cur_way       = in_lookup ? res_way       : way_q;
  assign cur_evict     = in_lookup ? res_evict     : evict_q;
  assign cur_evict_tag = in_lookup ? res_evict_tag : evict_tag_q;

  // hits of an id with misses in flight follow the miss path
  assign route_miss   = raised_q ? route_miss_q : (to_miss | ~cur_hit);
  assign send         = have_res & (raised_q | ~(locked | cnt_stall));
  assign hit_valid_o  = send & ~route_miss;
  assign miss_valid_o = send & route_miss;
  assign xfer         = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

  assign lock_req = xfer;
  assign cnt_up   = miss_valid_o & miss_ready_i;

  assign addr_o      = addr_q;
  assign rw_o        = rw_q;
  assign id_o        = id_q;
  assign way_o       = cur_way;
  assign refill_o    = ~cur_hit;
  assign evict_o     = cur_evict;
  assign evict_tag_o = cur_evict_tag;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      llc_pkg::HM_IDLE: begin
        if (accept) begin
          state_d = llc_pkg::HM_LOOKUP;
        end
      end
      llc_pkg::HM_LOOKUP: begin
        if (store_res_valid) begin
          state_d = xfer ? llc_pkg::HM_IDLE : llc_pkg::HM_SEND;
        end
      end
      llc_pkg::HM_SEND: begin
        if (xfer) begin
          state_d = llc_pkg::HM_IDLE;
        end
      end
      default: state_d = llc_pkg::HM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= llc_pkg::HM_IDLE;
      raised_q     <= 1'b0;
      route_miss_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (xfer) begin
        raised_q <= 1'b0;
      end else if (send) begin
        raised_q <= 1'b1;
      end
      // freeze the path when the valid first rises
      if (send && !raised_q) begin
        route_miss_q <= route_miss;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
      rw_q   <= rw_i;
      id_q   <= id_i;
    end
    if (in_lookup && store_res_valid) begin
      hit_q       <= res_hit;
      way_q       <= res_way;
      evict_q     <= res_evict;
      evict_tag_q <= res_evict_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  llc_tag_store u_tag_store (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (store_req_valid),
    .req_ready_o     (store_req_ready),
    .req_index_i     (addr_i[`LLC_OFFSET_W +: `LLC_INDEX_W]),
    .req_tag_i       (addr_i[`LLC_OFFSET_W + `LLC_INDEX_W +: `LLC_TAG_W]),
    .req_write_i     (rw_i),
    .res_valid_o     (store_res_valid),
    .res_ready_i     (store_res_ready),
    .res_hit_o       (res_hit),
    .res_way_o       (res_way),
    .res_evict_o     (res_evict),
    .res_evict_tag_o (res_evict_tag)
  );

  llc_miss_counters u_miss_counters (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .id_i      (id_q),
    .up_i      (cnt_up),
    .down_i    (cnt_down_i),
    .down_id_i (cnt_down_id_i),
    .to_miss_o (to_miss),
    .stall_o   (cnt_stall)
  );

  llc_lock_table u_lock_table (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lock_i         (lock_req),
    .index_i        (addr_q[`LLC_OFFSET_W +: `LLC_INDEX_W]),
    .way_i          (cur_way),
    .unlock_i       (unlock_i),
    .unlock_index_i (unlock_index_i),
    .unlock_way_i   (unlock_way_i),
    .locked_o       (locked)
  );

endmodule

`default_nettype wire

/* llc_hit_miss_properties.sv */
/*
  LLC hit/miss stage properties
  handshake rules of the two output paths, bound to the top level
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module llc_hit_miss_properties (
  input wire logic                    clk_i,
  input wire logic                    arst_n_i,
  input wire logic                    ready_o,
  input wire logic                    hit_valid_o,
  input wire logic                    hit_ready_i,
  input wire logic                    miss_valid_o,
  input wire logic                    miss_ready_i,
  input wire logic [`LLC_ADDR_W-1:0]  addr_o,
  input wire logic                    rw_o,
  input wire logic [`LLC_ID_W-1:0]    id_o,
  input wire logic [`LLC_WAYS-1:0]    way_o,
  input wire logic                    refill_o,
  input wire logic                    evict_o,
  input wire logic [`LLC_TAG_W-1:0]   evict_tag_o
);

  // number of failed assertions so far
  int unsigned fails = 0;

  // one path at a time
  a_one_path: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(hit_valid_o && miss_valid_o)) else begin
    $error("both output valids high");
    fails++;
  end

  a_way_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(way_o)) else begin
    $error("way_o not one-hot");
    fails++;
  end

  // a raised valid waits for its ready with frozen fields
  a_hit_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o && !hit_ready_i) |=> (hit_valid_o &&
      $stable({addr_o, rw_o, id_o, way_o, refill_o, evict_o, evict_tag_o})))
    else begin
    $error("hit valid dropped or fields changed");
    fails++;
  end

  a_miss_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (miss_valid_o && !miss_ready_i) |=> (miss_valid_o &&
      $stable({addr_o, rw_o, id_o, way_o, refill_o, evict_o, evict_tag_o})))
    else begin
    $error("miss valid dropped or fields changed");
    fails++;
  end

  a_no_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (hit_valid_o || miss_valid_o) |-> !ready_o) else begin
    $error("ready_o high during output");
    fails++;
  end

endmodule

bind llc_hit_miss llc_hit_miss_properties props0 (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .ready_o      (ready_o),
  .hit_valid_o  (hit_valid_o),
  .hit_ready_i  (hit_ready_i),
  .miss_valid_o (miss_valid_o),
  .miss_ready_i (miss_ready_i),
  .addr_o       (addr_o),
  .rw_o         (rw_o),
  .id_o         (id_o),
  .way_o        (way_o),
  .refill_o     (refill_o),
  .evict_o      (evict_o),
  .evict_tag_o  (evict_tag_o)
);

`default_nettype wire

/* tb_llc_hit_miss.sv */
/*
  LLC hit/miss stage testbench
  directed and LFSR random descriptors, downstream model with random readies,
  unlock and miss-done strobes, reference model of the tag arrays
*/
`timescale 1ns/1ps
`default_nettype none

`include "llc_cfg.svh"

module tb_llc_hit_miss;

  localparam int tmo_cycles = 3000;

  logic clk_i, arst_n_i, valid_i, ready_o, rw_i;
  logic hit_valid_o, hit_ready_i, miss_valid_o, miss_ready_i;
  logic rw_o, refill_o, evict_o, unlock_i, cnt_down_i;
  logic [31:0] addr_i, addr_o;
  logic [3:0]  id_i, id_o, way_o, unlock_index_i, unlock_way_i, cnt_down_id_i;
  logic [21:0] evict_tag_o;

  // reference tag arrays and replacement pointers
  logic [21:0] m_tag [16][4];
  logic [3:0]  m_valid [16];
  logic [3:0]  m_dirty [16];
  int          m_ptr [16];
  int          tb_cnt [16];

  // accepted descriptors and pending downstream returns
  logic [31:0] exp_addr [$];
  logic        exp_rw [$];
  logic [3:0]  exp_id [$];
  logic [7:0]  unlock_q [$];
  logic [3:0]  done_q [$];

  logic [31:0] lfsr;
  logic        auto_unlock, auto_done;
  int          errors, tests_run, tests_failed, xfer_cnt, err0, evicts, prop_seen;
  // last observed transfer
  logic        last_hit_path, last_refill, last_evict;
  logic [3:0]  last_way;
  logic [21:0] last_etag;
  // monitor scratch
  logic [31:0] ma;
  logic        mw, ehit, eevict, ehit_path;
  logic [3:0]  mid, eway;
  logic [21:0] etag;

  llc_hit_miss dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      // one Galois step per bit taken
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic void ref_lookup(input logic [31:0] a, input logic w, output logic hit,
                                     output logic [3:0] way, output logic ev,
                                     output logic [21:0] ev_tag);
    int s;
    int v;
    logic [21:0] t;
    s = a[9:6];
    t = a[31:10];
    hit = 1'b0;
    ev = 1'b0;
    ev_tag = '0;
    v = -1;
    for (int k = 0; k < 4; k++) begin
      if (m_valid[s][k] && m_tag[s][k] == t) begin
        hit = 1'b1;
        v = k;
      end
    end
    if (hit) begin
      m_dirty[s][v] = m_dirty[s][v] | w;
    end else begin
      // lowest invalid way first
      for (int k = 3; k >= 0; k--) begin
        if (!m_valid[s][k]) v = k;
      end
      if (v < 0) begin
        v = m_ptr[s];
        ev = m_dirty[s][v];
        ev_tag = m_tag[s][v];
        m_ptr[s] = (m_ptr[s] + 1) % 4;
      end
      m_tag[s][v] = t;
      m_valid[s][v] = 1'b1;
      m_dirty[s][v] = w;
    end
    way = 4'b0001 << v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // downstream model and compare
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    hit_ready_i  = |rand_bits(2);
    miss_ready_i = |rand_bits(2);
    unlock_i     = 1'b0;
    cnt_down_i   = 1'b0;
    // returns only while no output is offered
    if (arst_n_i && !hit_valid_o && !miss_valid_o) begin
      if (auto_unlock && unlock_q.size() > 0 && rand_bits(1)) begin
        {unlock_index_i, unlock_way_i} = unlock_q.pop_front();
        unlock_i = 1'b1;
      end
      if (auto_done && done_q.size() > 0 && rand_bits(1)) begin
        cnt_down_id_i = done_q.pop_front();
        tb_cnt[cnt_down_id_i]--;
        cnt_down_i = 1'b1;
      end
    end
  end

  always @(negedge clk_i) begin
    if (arst_n_i && ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i))) begin
      assert (exp_addr.size() > 0) else begin
        $display("Transfer seen at %0t with no descriptor outstanding", $time);
        errors++;
      end
      if (exp_addr.size() > 0) begin
        ma = exp_addr.pop_front();
        mw = exp_rw.pop_front();
        mid = exp_id.pop_front();
        ref_lookup(ma, mw, ehit, eway, eevict, etag);
        // hits of an id with misses downstream take the miss path
        ehit_path = ehit && (tb_cnt[mid] == 0);
        assert (addr_o == ma && rw_o == mw && id_o == mid) else begin
          $display("Fail %0t: descriptor fields %h/%b/%h, expected %h/%b/%h",
                   $time, addr_o, rw_o, id_o, ma, mw, mid);
          errors++;
        end
        assert (hit_valid_o == ehit_path) else begin
          $display("Fail %0t: wrong path for %h, hit path expected %b", $time, ma, ehit_path);
          errors++;
        end
        assert (way_o == eway && refill_o == !ehit) else begin
          $display("Fail %0t: way %b refill %b, expected %b %b",
                   $time, way_o, refill_o, eway, !ehit);
          errors++;
        end
        assert (evict_o == eevict && (!eevict || evict_tag_o == etag)) else begin
          $display("Fail %0t: evict %b tag %h, expected %b %h",
                   $time, evict_o, evict_tag_o, eevict, etag);
          errors++;
        end
        last_hit_path = hit_valid_o;
        last_refill = refill_o;
        last_evict = evict_o;
        last_way = way_o;
        last_etag = evict_tag_o;
        unlock_q.push_back({addr_o[9:6], way_o});
        if (miss_valid_o) begin
          tb_cnt[mid]++;
          done_q.push_back(mid);
        end
        xfer_cnt++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("Timeout: %s at %0t", why, $time);
    $display("Test failures found");
    $finish;
  endtask

  task automatic send_desc(input logic [31:0] a, input logic w, input logic [3:0] id);
    int t;
    t = 0;
    @(posedge clk_i);
    #1;
    valid_i = 1'b1;
    addr_i = a;
    rw_i = w;
    id_i = id;
    @(negedge clk_i);
    while (!ready_o) begin
      t++;
      if (t > tmo_cycles) abort_run("descriptor never accepted");
      @(negedge clk_i);
    end
    exp_addr.push_back(a);
    exp_rw.push_back(w);
    exp_id.push_back(id);
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic wait_xfers(input int target);
    int t;
    t = 0;
    while (xfer_cnt < target) begin
      t++;
      if (t > tmo_cycles) abort_run("output transfer missing");
      @(negedge clk_i);
    end
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    while (unlock_q.size() > 0 || done_q.size() > 0) begin
      t++;
      if (t > tmo_cycles) abort_run("downstream returns not drained");
      @(negedge clk_i);
    end
  endtask

  task automatic end_test(input string name);
    int p;
    // handshake property failures count against the running test
    p = dut0.props0.fails;
    errors = errors + p - prop_seen;
    prop_seen = p;
    tests_run++;
    if (errors > err0) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errors > err0) ? "FAILED" : "ok");
    err0 = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int t;
    logic [2:0] r_tag;
    logic [1:0] r_set;
    logic [5:0] r_off;
    logic       r_w;
    logic [1:0] r_id;
    lfsr = 32'h523c_9382;
    arst_n_i = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    rw_i = 1'b0;
    id_i = '0;
    hit_ready_i = 1'b0;
    miss_ready_i = 1'b0;
    unlock_i = 1'b0;
    unlock_index_i = '0;
    unlock_way_i = '0;
    cnt_down_i = 1'b0;
    cnt_down_id_i = '0;
    auto_unlock = 1'b1;
    auto_done = 1'b1;
    errors = 0;
    err0 = 0;
    prop_seen = 0;
    tests_run = 0;
    tests_failed = 0;
    xfer_cnt = 0;
    for (int s = 0; s < 16; s++) begin
      m_valid[s] = '0;
      m_dirty[s] = '0;
      m_ptr[s] = 0;
      tb_cnt[s] = 0;
      for (int k = 0; k < 4; k++) m_tag[s][k] = '0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // init sweep keeps the stage closed
    repeat (`LLC_SETS) begin
      @(negedge clk_i);
      assert (!ready_o && !hit_valid_o && !miss_valid_o) else begin
        $display("Fail %0t: stage active during init sweep", $time);
        errors++;
      end
    end
    t = 0;
    while (!ready_o) begin
      t++;
      if (t > tmo_cycles) abort_run("ready_o never rose after init");
      @(negedge clk_i);
    end
    end_test("init sweep");

    // empty set fills its lowest way
    send_desc({22'h0a1, 4'd3, 6'd0}, 1'b0, 4'd1);
    wait_xfers(1);
    assert (!last_hit_path && last_refill && !last_evict && last_way == 4'b0001) else begin
      $display("Fail %0t: first access not a refill miss in way 0001", $time);
      errors++;
    end
    wait_drained();
    send_desc({22'h0a1, 4'd3, 6'd8}, 1'b0, 4'd1);
    wait_xfers(2);
    assert (last_hit_path && last_way == 4'b0001) else begin
      $display("Fail %0t: repeat access not a hit in way 0001", $time);
      errors++;
    end
    end_test("miss then hit");

    evicts = 0;
    for (int k = 0; k < 8; k++) begin
      send_desc({22'h100 + k[21:0], 4'd5, 6'd0}, 1'b1, 4'd2);
      wait_xfers(3 + k);
      if (last_evict) begin
        // pointer order replaces oldest fills first
        assert (last_etag == 22'h100 + evicts) else begin
          $display("Fail %0t: evicted tag %h out of order", $time, last_etag);
          errors++;
        end
        evicts++;
      end
    end
    assert (evicts == 4) else begin
      $display("Fail %0t: %0d dirty evictions, expected 4", $time, evicts);
      errors++;
    end
    end_test("fill and evict");

    wait_drained();
    auto_unlock = 1'b0;
    send_desc({22'h033, 4'd12, 6'd0}, 1'b0, 4'd3);
    wait_xfers(11);
    send_desc({22'h033, 4'd12, 6'd4}, 1'b0, 4'd3);
    repeat (20) begin
      @(negedge clk_i);
      assert (!hit_valid_o && !miss_valid_o) else begin
        $display("Fail %0t: locked line delivered", $time);
        errors++;
      end
    end
    auto_unlock = 1'b1;
    wait_xfers(12);
    end_test("line lock");

    wait_drained();
    auto_done = 1'b0;
    send_desc({22'h044, 4'd9, 6'd0}, 1'b0, 4'd7);
    wait_xfers(13);
    t = 0;
    while (unlock_q.size() > 0) begin
      t++;
      if (t > tmo_cycles) abort_run("unlock not issued");
      @(negedge clk_i);
    end
    send_desc({22'h044, 4'd9, 6'd0}, 1'b0, 4'd7);
    wait_xfers(14);
    assert (!last_hit_path && !last_refill) else begin
      $display("Fail %0t: hit with miss in flight not on miss path", $time);
      errors++;
    end
    auto_done = 1'b1;
    wait_drained();
    send_desc({22'h044, 4'd9, 6'd0}, 1'b0, 4'd7);
    wait_xfers(15);
    assert (last_hit_path) else begin
      $display("Fail %0t: hit after miss-done not on hit path", $time);
      errors++;
    end
    end_test("miss in flight");

    // eight tags over sets 0 to 3, ids 0 to 3
    for (int n = 0; n < 300; n++) begin
      // fields drawn at the falling edge, away from the downstream LFSR steps
      @(negedge clk_i);
      r_tag = rand_bits(3);
      r_set = rand_bits(2);
      r_off = rand_bits(6);
      r_w   = rand_bits(1);
      r_id  = rand_bits(2);
      send_desc({19'd0, r_tag, 2'b00, r_set, r_off}, r_w, {2'b00, r_id});
    end
    wait_xfers(315);
    wait_drained();
    end_test("random mix");

    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
llc_pkg.sv
llc_tag_store.sv
llc_miss_counters.sv
llc_lock_table.sv
llc_hit_miss.sv
llc_hit_miss_properties.sv
tb_llc_hit_miss.sv
